//--- hdl/alloc_if.sv
`timescale 1ns/1ps
`default_nettype none

interface alloc_if;
	import mov_core_pkg::*;

	logic valid;
	logic ready;
	logic [TAG_W-1:0] tag;  // Next free slot, valid whenever ready is high
	logic [REG_W-1:0] rd;

	modport req (
		output valid,
		output rd,
		input ready,
		input tag
	);

	modport rob (
		input valid,
		input rd,
		output ready,
		output tag
	);
endinterface

`default_nettype wire

//--- hdl/gpr_rename_file.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_rename_file (
	input logic clk,
	input logic reset,
	input logic [mov_core_pkg::REG_W-1:0] rs_index,
	output mov_core_pkg::operand_t rs_read,
	input logic rename_valid,
	input logic [mov_core_pkg::REG_W-1:0] rename_rd,
	input logic [mov_core_pkg::TAG_W-1:0] rename_tag,
	input mov_core_pkg::cdb_t cdb
);
	import mov_core_pkg::*;

	localparam int NREG = 1 << REG_W;

	logic [XLEN-1:0] value [NREG];
	logic [NREG-1:0] busy;
	logic [TAG_W-1:0] tag [NREG];
	logic cdb_hit;

	assign cdb_hit = cdb.valid && cdb.tag == tag[rs_index];

	always_comb begin
		if (!busy[rs_index]) begin
			rs_read.valid = 1'b1;
			rs_read.tag = '0;
			rs_read.data = value[rs_index];
		end else if (cdb_hit) begin
			rs_read.valid = 1'b1;  // Producer is broadcasting this very cycle
			rs_read.tag = tag[rs_index];
			rs_read.data = cdb.data;
		end else begin
			rs_read.valid = 1'b0;
			rs_read.tag = tag[rs_index];
			rs_read.data = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
			for (int i = 0; i < NREG; i++) begin
				value[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NREG; i++) begin
				if (rename_valid && rename_rd == REG_W'(i)) begin
					busy[i] <= 1'b1;  // A new producer takes over the register
					tag[i] <= rename_tag;
				end else if (cdb.valid && busy[i] && tag[i] == cdb.tag) begin
					busy[i] <= 1'b0;
					value[i] <= cdb.data;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_if;
	import mov_core_pkg::*;

	logic valid;
	logic ready;
	mov_op_e op;
	logic [TAG_W-1:0] tag;  // Reorder-buffer slot of the instruction
	operand_t operand;

	modport dec (
		output valid,
		output op,
		output tag,
		output operand,
		input ready
	);

	modport rs (
		input valid,
		input op,
		input tag,
		input operand,
		output ready
	);
endinterface

`default_nettype wire

//--- hdl/mov_core.sv
`timescale 1ns/1ps
`default_nettype none

module mov_core #(
	parameter int RS_DEPTH = 2
) (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	output logic inst_ready,
	input mov_core_pkg::mov_op_e inst_op,
	input logic [mov_core_pkg::REG_W-1:0] inst_rd,
	input logic [mov_core_pkg::REG_W-1:0] inst_rs,
	input logic [mov_core_pkg::IMM_W-1:0] inst_imm,
	output logic retire_valid,
	output logic [mov_core_pkg::REG_W-1:0] retire_rd,
	output logic [mov_core_pkg::XLEN-1:0] retire_data
);
	import mov_core_pkg::*;

	issue_if issue_bus ();
	alloc_if alloc_bus ();

	cdb_t cdb;
	operand_t rs_read;
	logic [REG_W-1:0] rs_index;
	logic rename_valid;
	logic [REG_W-1:0] rename_rd;

	mov_decode decode_i (
		.clk(clk),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst_op(inst_op),
		.inst_rd(inst_rd),
		.inst_rs(inst_rs),
		.inst_imm(inst_imm),
		.rs_read(rs_read),
		.rs_index(rs_index),
		.rename_valid(rename_valid),
		.rename_rd(rename_rd),
		.alloc(alloc_bus.req),
		.issue(issue_bus.dec)
	);

	gpr_rename_file gpr_i (
		.clk(clk),
		.reset(reset),
		.rs_index(rs_index),
		.rs_read(rs_read),
		.rename_valid(rename_valid),
		.rename_rd(rename_rd),
		.rename_tag(alloc_bus.tag),
		.cdb(cdb)
	);

	mov_station #(.RS_DEPTH(RS_DEPTH)) station_i (
		.clk(clk),
		.reset(reset),
		.issue(issue_bus.rs),
		.cdb(cdb)
	);

	mov_rob rob_i (
		.clk(clk),
		.reset(reset),
		.alloc(alloc_bus.rob),
		.cdb(cdb),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_data(retire_data)
	);

endmodule

`default_nettype wire

//--- hdl/mov_core_pkg.sv
`default_nettype none

package mov_core_pkg;

	localparam int XLEN = 32;
	localparam int IMM_W = 16;
	localparam int REG_W = 4;
	localparam int TAG_W = 3;
	localparam int ROB_DEPTH = 1 << TAG_W;  // One tag per reorder-buffer slot

	typedef enum logic [0:0] {
		MOV_REG = 1'b0,
		MOV_IMM = 1'b1
	} mov_op_e;

	// Result broadcast from the station to every waiting consumer
	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0] data;
	} cdb_t;

	typedef struct packed {
		logic valid;  // Set when data holds the value, clear while waiting on tag
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0] data;
	} operand_t;

endpackage

`default_nettype wire

//--- hdl/mov_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mov_decode (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	output logic inst_ready,
	input mov_core_pkg::mov_op_e inst_op,
	input logic [mov_core_pkg::REG_W-1:0] inst_rd,
	input logic [mov_core_pkg::REG_W-1:0] inst_rs,
	input logic [mov_core_pkg::IMM_W-1:0] inst_imm,
	input mov_core_pkg::operand_t rs_read,
	output logic [mov_core_pkg::REG_W-1:0] rs_index,
	output logic rename_valid,
	output logic [mov_core_pkg::REG_W-1:0] rename_rd,
	alloc_if.req alloc,
	issue_if.dec issue
);
	import mov_core_pkg::*;

	logic active;
	logic accept;
	operand_t imm_operand;

	// Holds the input closed for the first cycle out of reset
	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
		end else begin
			active <= 1'b1;
		end
	end

	assign inst_ready = active && alloc.ready && issue.ready;
	assign accept = inst_valid && inst_ready;

	assign imm_operand.valid = 1'b1;
	assign imm_operand.tag = '0;
	assign imm_operand.data = {{(XLEN-IMM_W){inst_imm[IMM_W-1]}}, inst_imm};

	assign rs_index = inst_rs;

	assign alloc.valid = accept;
	assign alloc.rd = inst_rd;

	assign issue.valid = accept;
	assign issue.op = inst_op;
	assign issue.tag = alloc.tag;
	assign issue.operand = (inst_op == MOV_IMM) ? imm_operand : rs_read;

	assign rename_valid = accept;  // Destination now waits on the new tag
	assign rename_rd = inst_rd;

endmodule

`default_nettype wire

//--- hdl/mov_rob.sv
`timescale 1ns/1ps
`default_nettype none

module mov_rob (
	input logic clk,
	input logic reset,
	alloc_if.rob alloc,
	input mov_core_pkg::cdb_t cdb,
	output logic retire_valid,
	output logic [mov_core_pkg::REG_W-1:0] retire_rd,
	output logic [mov_core_pkg::XLEN-1:0] retire_data
);
	import mov_core_pkg::*;

	logic [ROB_DEPTH-1:0] slot_valid;
	logic [ROB_DEPTH-1:0] slot_done;
	logic [REG_W-1:0] slot_rd [ROB_DEPTH];
	logic [XLEN-1:0] slot_data [ROB_DEPTH];
	logic [TAG_W-1:0] head;
	logic [TAG_W-1:0] tail;
	logic [TAG_W:0] count;
	logic alloc_fire;
	logic head_hit;
	logic retire_fire;

	assign alloc.ready = count != (TAG_W+1)'(ROB_DEPTH);
	assign alloc.tag = tail;
	assign alloc_fire = alloc.valid && alloc.ready;

	// The head may retire in the same cycle its result is broadcast
	assign head_hit = cdb.valid && cdb.tag == head;
	assign retire_fire = slot_valid[head] && (slot_done[head] || head_hit);

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid <= '0;
			slot_done <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			retire_valid <= 1'b0;
		end else begin
			if (cdb.valid) begin
				slot_done[cdb.tag] <= 1'b1;
			end
			if (alloc_fire) begin
				slot_valid[tail] <= 1'b1;
				slot_done[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			if (retire_fire) begin
				slot_valid[head] <= 1'b0;  // Slot becomes free for a new tag
				slot_done[head] <= 1'b0;
				head <= head + 1'b1;
			end
			count <= count + (TAG_W+1)'(alloc_fire) - (TAG_W+1)'(retire_fire);
			retire_valid <= retire_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (cdb.valid) begin
			slot_data[cdb.tag] <= cdb.data;
		end
		if (alloc_fire) begin
			slot_rd[tail] <= alloc.rd;
		end
		if (retire_fire) begin
			retire_rd <= slot_rd[head];
			retire_data <= slot_done[head] ? slot_data[head] : cdb.data;
		end
	end

endmodule

`default_nettype wire

//--- hdl/mov_station.sv
`timescale 1ns/1ps
`default_nettype none

module mov_station #(
	parameter int RS_DEPTH = 2
) (
	input logic clk,
	input logic reset,
	issue_if.rs issue,
	output mov_core_pkg::cdb_t cdb
);
	import mov_core_pkg::*;

	localparam int SEL_W = $clog2(RS_DEPTH);

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		operand_t opd;
	} rs_entry_t;

	rs_entry_t e [RS_DEPTH];  // Packed from index 0, oldest first
	rs_entry_t e_upd [RS_DEPTH+1];
	rs_entry_t shifted [RS_DEPTH];
	rs_entry_t e_next [RS_DEPTH];
	rs_entry_t e_new;
	logic [RS_DEPTH-1:0] dispatchable;
	logic [SEL_W-1:0] sel_idx;
	logic take_entry;
	logic take_new;
	logic accept;
	logic store_new;

	assign e_new.valid = issue.valid;
	assign e_new.tag = issue.tag;
	assign e_new.opd.valid = issue.op == MOV_IMM || issue.operand.valid;
	assign e_new.opd.tag = issue.operand.tag;
	assign e_new.opd.data = issue.operand.data;

	for (genvar i = 0; i < RS_DEPTH; i++) begin : g_snoop
		logic hit;

		assign hit = cdb.valid && cdb.tag == e[i].opd.tag;
		assign e_upd[i].valid = e[i].valid;
		assign e_upd[i].tag = e[i].tag;
		assign e_upd[i].opd.valid = e[i].opd.valid || hit;
		assign e_upd[i].opd.tag = e[i].opd.tag;
		assign e_upd[i].opd.data = e[i].opd.valid ? e[i].opd.data : cdb.data;
		assign dispatchable[i] = e_upd[i].valid && e_upd[i].opd.valid;
	end
	assign e_upd[RS_DEPTH] = '0;  // Empty slot shifted into the top on dispatch

	always_comb begin
		sel_idx = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (dispatchable[i]) begin
				sel_idx = SEL_W'(i);
			end
		end
	end

	assign take_entry = |dispatchable;
	assign issue.ready = !e[RS_DEPTH-1].valid || take_entry;
	assign accept = issue.valid && issue.ready;
	assign take_new = !take_entry && accept && e_new.opd.valid;  // Bypass straight to the CDB
	assign store_new = accept && !take_new;

	always_comb begin
		logic prev_valid;

		prev_valid = 1'b1;
		for (int i = 0; i < RS_DEPTH; i++) begin
			shifted[i] = (take_entry && i >= int'(sel_idx)) ? e_upd[i+1] : e_upd[i];
			e_next[i] = shifted[i];
			// New entry lands in the first free slot after the shift
			if (store_new && prev_valid && !shifted[i].valid) begin
				e_next[i] = e_new;
			end
			prev_valid = shifted[i].valid;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				e[i] <= '0;
			end
			cdb.valid <= 1'b0;
		end else begin
			e <= e_next;
			cdb.valid <= take_entry || take_new;
		end
		cdb.tag <= take_entry ? e_upd[sel_idx].tag : e_new.tag;
		cdb.data <= take_entry ? e_upd[sel_idx].opd.data : e_new.opd.data;
	end

endmodule

`default_nettype wire

//--- mov_core.f
hdl/mov_core_pkg.sv
hdl/issue_if.sv
hdl/alloc_if.sv
hdl/gpr_rename_file.sv
hdl/mov_decode.sv
hdl/mov_station.sv
hdl/mov_rob.sv
hdl/mov_core.sv
verification/mov_core_assert.sv
verification/mov_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the mov_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module mov_core_tb -Mdir obj_dir -o mov_core_sim \
	-f mov_core.f

./obj_dir/mov_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

//--- verification/mov_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mov_core_assert (
	input logic clk,
	input logic reset,
	input logic inst_ready,
	input logic retire_valid,
	input logic [mov_core_pkg::REG_W-1:0] retire_rd,
	input logic cdb_valid,
	input logic [mov_core_pkg::TAG_W-1:0] cdb_tag,
	input logic [mov_core_pkg::ROB_DEPTH-1:0] slot_valid
);

	// Nothing moves in the first cycle out of reset
	a_quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !retire_valid && !inst_ready && !cdb_valid)
		else $error("Core active in the cycle after reset");

	a_retire_rd_known: assert property (@(posedge clk) disable iff (reset)
		retire_valid |-> !$isunknown(retire_rd))
		else $error("retire_rd unknown while retire_valid is high");

	a_cdb_slot_allocated: assert property (@(posedge clk) disable iff (reset)
		cdb_valid |-> slot_valid[cdb_tag])  // Tag must name a live reorder-buffer slot
		else $error("CDB broadcast for a free reorder-buffer slot");

endmodule

bind mov_core mov_core_assert assert_i (
	.clk(clk),
	.reset(reset),
	.inst_ready(inst_ready),
	.retire_valid(retire_valid),
	.retire_rd(retire_rd),
	.cdb_valid(cdb.valid),
	.cdb_tag(cdb.tag),
	.slot_valid(rob_i.slot_valid)
);

`default_nettype wire

//--- verification/mov_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mov_core_tb;
	import mov_core_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;  // About ten cycles per instruction sent
	localparam int DRAIN_CYCLES = 50;  // Far above the retire latency of a full reorder buffer

	logic clk;
	logic reset;
	logic inst_valid;
	logic inst_ready;
	mov_op_e inst_op;
	logic [REG_W-1:0] inst_rd;
	logic [REG_W-1:0] inst_rs;
	logic [IMM_W-1:0] inst_imm;
	logic retire_valid;
	logic [REG_W-1:0] retire_rd;
	logic [XLEN-1:0] retire_data;

	logic [XLEN-1:0] ref_regs [1 << REG_W];  // Architectural state in program order
	logic [REG_W-1:0] exp_rd [$];
	logic [XLEN-1:0] exp_data [$];
	int cycles = 0;

	mov_core #(.RS_DEPTH(2)) dut_i (.*);

	always #20 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic check(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
			input string msg);
		if (actual !== expected) begin
			abort_run($sformatf("Mismatch at %0t ns: %s: got %h, expected %h",
				$time, msg, actual, expected));
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timeout: tests still running after %0d cycles", cycles));
		end
	end

	always @(posedge clk) begin
		if (!reset && retire_valid) begin
			if (exp_rd.size() == 0) begin
				abort_run($sformatf("Unexpected retirement of r%0d at %0t ns", retire_rd, $time));
			end else begin
				check(XLEN'(retire_rd), XLEN'(exp_rd.pop_front()), "retire_rd");
				check(retire_data, exp_data.pop_front(), "retire_data");
			end
		end
	end

	task automatic send(input mov_op_e op, input int rd, input int rs, input int imm);
		logic [XLEN-1:0] value;
		@(negedge clk);
		inst_valid = 1'b1;
		inst_op = op;
		inst_rd = REG_W'(rd);
		inst_rs = REG_W'(rs);
		inst_imm = IMM_W'(imm);
		while (!inst_ready) begin
			@(negedge clk);  // Ready depends on state only, so it holds until the next edge
		end
		@(posedge clk);
		if (op == MOV_IMM) begin
			value = XLEN'($signed(inst_imm));
		end else begin
			value = ref_regs[inst_rs];
		end
		ref_regs[inst_rd] = value;
		exp_rd.push_back(inst_rd);
		exp_data.push_back(value);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			inst_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int waited;
		idle(1);
		waited = 0;
		while (exp_rd.size() != 0 && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		check(XLEN'(exp_rd.size()), '0, "results left after drain");
		idle(3);  // Any extra retirement shows up in the monitor
	endtask

	task automatic test_reset();
		idle(5);
		check(XLEN'(retire_valid), '0, "retire_valid with no input");
	endtask

	task automatic test_imm();
		send(MOV_IMM, 1, 0, 16'h1234);
		send(MOV_IMM, 2, 0, 16'h8001);
		send(MOV_IMM, 3, 0, 16'hffff);
		send(MOV_IMM, 4, 0, 16'h7fff);
		drain();
	endtask

	task automatic test_reg();
		send(MOV_REG, 5, 9, 0);  // Never written so far
		send(MOV_IMM, 1, 0, -42);
		send(MOV_REG, 2, 1, 0);
		send(MOV_REG, 3, 2, 0);
		drain();
	endtask

	task automatic test_ooo();
		send(MOV_IMM, 7, 0, 100);
		send(MOV_REG, 8, 7, 0);
		send(MOV_IMM, 9, 0, -5);
		send(MOV_REG, 10, 8, 0);
		send(MOV_IMM, 11, 0, 77);
		send(MOV_REG, 12, 10, 0);
		drain();
	endtask

	task automatic test_burst();
		for (int i = 0; i < 20; i++) begin
			if (i % 2 == 1) begin
				send(MOV_REG, (i % 15) + 1, i % 15, 0);
			end else begin
				send(MOV_IMM, i % 16, 0, i * 1111 - 9000);
			end
		end
		drain();
	endtask

	task automatic test_random();
		for (int i = 0; i < 100; i++) begin
			send(mov_op_e'($urandom_range(0, 1)), $urandom % 16, $urandom % 16, $urandom);
			idle($urandom % 3);
		end
		drain();
	endtask

	initial begin
		void'($urandom(43668));
		clk = 1'b0;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst_op = MOV_IMM;
		inst_rd = '0;
		inst_rs = '0;
		inst_imm = '0;
		for (int i = 0; i < (1 << REG_W); i++) begin
			ref_regs[i] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset();
		test_imm();
		test_reg();
		test_ooo();
		test_burst();
		test_random();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
